// File: Makefile
VERILATOR  ?= verilator
TOP        := soc_fabric_tb
RTL_TOP    := soc_fabric_top
FILELIST   := soc_fabric_top.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// File: include/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus geometry
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8
`define SOC_TAG_W 4

// Host credits match the queue depth
`define SOC_REQ_CREDITS 4

`define SOC_L2_WORDS 1024
`define SOC_APB_W 32

`endif

// File: rtl/addr_router.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module addr_router (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  soc_bus_pkg::bus_req_t head_i,
  input  logic                  head_valid_i,
  output logic                  pop_o,
  output soc_bus_pkg::tgt_req_t l2_req_o,
  output soc_bus_pkg::tgt_req_t uart_req_o,
  output soc_bus_pkg::tgt_req_t ctrl_req_o,
  input  soc_bus_pkg::tgt_rsp_t l2_rsp_i,
  input  soc_bus_pkg::tgt_rsp_t uart_rsp_i,
  input  soc_bus_pkg::tgt_rsp_t ctrl_rsp_i,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e                 state_q;
  soc_target_e            sel;
  soc_target_e            tgt_q;
  logic [`SOC_ADDR_W-1:0] base;
  logic [`SOC_TAG_W-1:0]  tag_q;
  tgt_req_t               fwd;
  tgt_rsp_t               done_rsp;
  logic                   rsp_valid_q;
  bus_rsp_t               rsp_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////
  always_comb begin
    sel  = TGT_NONE;
    base = '0;
    if (in_window(head_i.addr, DRAM_BASE, DRAM_LEN)) begin
      sel  = TGT_L2;
      base = DRAM_BASE;
    end else if (in_window(head_i.addr, UART_BASE, UART_LEN)) begin
      sel  = TGT_UART;
      base = UART_BASE;
    end else if (in_window(head_i.addr, CTRL_BASE, CTRL_LEN)) begin
      sel  = TGT_CTRL;
      base = CTRL_BASE;
    end
  end

  assign pop_o = (state_q == ST_IDLE) && head_valid_i;

  // Strobe goes out in the pop cycle
  always_comb begin
    fwd.valid  = 1'b0;
    fwd.we     = head_i.we;
    fwd.addr   = head_i.addr - base;
    fwd.wdata  = head_i.wdata;
    fwd.strb   = head_i.strb;
    l2_req_o   = fwd;
    uart_req_o = fwd;
    ctrl_req_o = fwd;
    l2_req_o.valid   = pop_o && (sel == TGT_L2);
    uart_req_o.valid = pop_o && (sel == TGT_UART);
    ctrl_req_o.valid = pop_o && (sel == TGT_CTRL);
  end

  always_comb begin
    case (tgt_q)
      TGT_L2:   done_rsp = l2_rsp_i;
      TGT_UART: done_rsp = uart_rsp_i;
      TGT_CTRL: done_rsp = ctrl_rsp_i;
      default:  done_rsp = '0;
    endcase
  end

  //////////////////////////////
  // Control
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (pop_o) begin
            // Unmapped requests answer at once
            if (sel == TGT_NONE) begin
              rsp_valid_q <= 1'b1;
            end else begin
              state_q <= ST_BUSY;
            end
          end
        end
        default: begin
          if (done_rsp.done) begin
            rsp_valid_q <= 1'b1;
            state_q     <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      tag_q <= head_i.tag;
      tgt_q <= sel;
    end
    if (pop_o && (sel == TGT_NONE)) begin
      rsp_q.tag   <= head_i.tag;
      rsp_q.rdata <= '0;
      rsp_q.err   <= 1'b1;
    end else if ((state_q == ST_BUSY) && done_rsp.done) begin
      rsp_q.tag   <= tag_q;
      rsp_q.rdata <= done_rsp.rdata;
      rsp_q.err   <= done_rsp.err;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  a_no_done_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == ST_IDLE) |-> !(l2_rsp_i.done || uart_rsp_i.done || ctrl_rsp_i.done))
    else $error("addr_router: target done with no request outstanding");

endmodule

// File: rtl/credit_req_queue.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module credit_req_queue (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  push_i,
  input  soc_bus_pkg::bus_req_t push_data_i,
  input  logic                  pop_i,
  output soc_bus_pkg::bus_req_t head_o,
  output logic                  head_valid_o,
  output logic                  credit_o
);
  import soc_bus_pkg::*;

  localparam int unsigned Depth = `SOC_REQ_CREDITS;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  bus_req_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  // Each freed slot goes straight back to the host
  assign credit_o     = pop_i;

  a_push_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (count_q != CntW'(Depth)))
    else $error("credit_req_queue: request pushed without a credit");

  a_pop_needs_entry: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> (count_q != '0))
    else $error("credit_req_queue: pop from empty queue");

endmodule

// File: rtl/ctrl_regs.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  soc_bus_pkg::tgt_req_t  req_i,
  output soc_bus_pkg::tgt_rsp_t  rsp_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [`SOC_DATA_W-1:0] exit_q;
  logic [`SOC_DATA_W-1:0] cnt_en_q;
  logic [`SOC_DATA_W-1:0] rd_word;
  logic                   bad;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   err_q;
  logic                   done_q;

  always_comb begin
    rd_word = '0;
    bad     = 1'b0;
    case (req_i.addr)
      CTRL_EXIT_OFS:   rd_word = exit_q;
      CTRL_CNT_EN_OFS: rd_word = cnt_en_q;
      CTRL_DRAM_BASE_OFS: begin
        rd_word = {{(`SOC_DATA_W - `SOC_ADDR_W){1'b0}}, DRAM_BASE};
        // read only
        bad     = req_i.we;
      end
      default: bad = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= req_i.valid;
      if (req_i.valid && req_i.we) begin
        case (req_i.addr)
          CTRL_EXIT_OFS:   exit_q   <= merge_bytes(exit_q, req_i.wdata, req_i.strb);
          CTRL_CNT_EN_OFS: cnt_en_q <= merge_bytes(cnt_en_q, req_i.wdata, req_i.strb);
          default:         ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= rd_word;
      err_q   <= bad;
    end
  end

  assign rsp_o.done  = done_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = err_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

// File: rtl/l2_mem.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module l2_mem (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  soc_bus_pkg::tgt_req_t req_i,
  output soc_bus_pkg::tgt_rsp_t rsp_o
);
  import soc_bus_pkg::*;

  localparam int unsigned LaneW = $clog2(`SOC_STRB_W);
  localparam int unsigned IdxW  = $clog2(`SOC_L2_WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_L2_WORDS];
  logic [IdxW-1:0]        idx;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   done_q;

  // Word index sits above the byte lane bits
  assign idx = req_i.addr[LaneW +: IdxW];

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        mem_q[idx] <= merge_bytes(mem_q[idx], req_i.wdata, req_i.strb);
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // One cycle latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= req_i.valid;
    end
  end

  assign rsp_o.done  = done_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

// File: rtl/soc_bus_pkg.sv
`include "soc_macros.svh"

package soc_bus_pkg;

  //////////////////////////////
  // Host port
  //////////////////////////////
  typedef struct packed {
    logic [`SOC_TAG_W-1:0]  tag;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_TAG_W-1:0]  tag;
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } bus_rsp_t;

  //////////////////////////////
  // Router to target
  //////////////////////////////
  // Address carries the offset inside the target window
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
  } tgt_req_t;

  typedef struct packed {
    logic                   done;
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } tgt_rsp_t;

  // Byte lane merge under strobe
  function automatic logic [`SOC_DATA_W-1:0] merge_bytes(
    input logic [`SOC_DATA_W-1:0] old_word,
    input logic [`SOC_DATA_W-1:0] new_word,
    input logic [`SOC_STRB_W-1:0] strb
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < `SOC_STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: rtl/soc_fabric_top.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_fabric_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_valid_i,
  input  soc_bus_pkg::bus_req_t  req_i,
  output logic                   credit_o,
  output logic                   rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t  rsp_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`SOC_APB_W-1:0]  uart_pwdata_o,
  input  logic [`SOC_APB_W-1:0]  uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i
);
  import soc_bus_pkg::*;

  bus_req_t head;
  logic     head_valid;
  logic     pop;
  tgt_req_t l2_req;
  tgt_req_t uart_req;
  tgt_req_t ctrl_req;
  tgt_rsp_t l2_rsp;
  tgt_rsp_t uart_rsp;
  tgt_rsp_t ctrl_rsp;

  //////////////////////////////
  // Request path
  //////////////////////////////
  credit_req_queue i_req_queue (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .push_i      (req_valid_i),
    .push_data_i (req_i      ),
    .pop_i       (pop        ),
    .head_o      (head       ),
    .head_valid_o(head_valid ),
    .credit_o    (credit_o   )
  );

  addr_router i_router (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .head_i      (head       ),
    .head_valid_i(head_valid ),
    .pop_o       (pop        ),
    .l2_req_o    (l2_req     ),
    .uart_req_o  (uart_req   ),
    .ctrl_req_o  (ctrl_req   ),
    .l2_rsp_i    (l2_rsp     ),
    .uart_rsp_i  (uart_rsp   ),
    .ctrl_rsp_i  (ctrl_rsp   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o      )
  );

  //////////////////////////////
  // Targets
  //////////////////////////////
  l2_mem i_l2 (
    .clk_i(clk_i ),
    .rst_i(rst_i ),
    .req_i(l2_req),
    .rsp_o(l2_rsp)
  );

  uart_apb_bridge i_uart (
    .clk_i    (clk_i         ),
    .rst_i    (rst_i         ),
    .req_i    (uart_req      ),
    .rsp_o    (uart_rsp      ),
    .psel_o   (uart_psel_o   ),
    .penable_o(uart_penable_o),
    .pwrite_o (uart_pwrite_o ),
    .paddr_o  (uart_paddr_o  ),
    .pwdata_o (uart_pwdata_o ),
    .prdata_i (uart_prdata_i ),
    .pready_i (uart_pready_i ),
    .pslverr_i(uart_pslverr_i)
  );

  ctrl_regs i_ctrl (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (ctrl_req   ),
    .rsp_o      (ctrl_rsp   ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

// File: rtl/soc_map_pkg.sv
`include "soc_macros.svh"

package soc_map_pkg;

  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_UART = 2'd1,
    TGT_CTRL = 2'd2,
    TGT_NONE = 2'd3
  } soc_target_e;

  //////////////////////////////
  // Memory map
  //////////////////////////////
  localparam logic [`SOC_ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;
  localparam logic [`SOC_ADDR_W-1:0] UART_BASE = 32'hC000_0000;
  localparam logic [`SOC_ADDR_W-1:0] CTRL_BASE = 32'hD000_0000;

  // 8 KiB of L2, one page each for the peripherals
  localparam logic [`SOC_ADDR_W-1:0] DRAM_LEN = 32'h0000_2000;
  localparam logic [`SOC_ADDR_W-1:0] UART_LEN = 32'h0000_1000;
  localparam logic [`SOC_ADDR_W-1:0] CTRL_LEN = 32'h0000_1000;

  // Control register offsets
  localparam logic [`SOC_ADDR_W-1:0] CTRL_EXIT_OFS      = 32'h0000_0000;
  localparam logic [`SOC_ADDR_W-1:0] CTRL_CNT_EN_OFS    = 32'h0000_0008;
  localparam logic [`SOC_ADDR_W-1:0] CTRL_DRAM_BASE_OFS = 32'h0000_0010;

  function automatic logic in_window(input logic [`SOC_ADDR_W-1:0] addr,
                                     input logic [`SOC_ADDR_W-1:0] base,
                                     input logic [`SOC_ADDR_W-1:0] len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

endpackage

// File: rtl/uart_apb_bridge.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module uart_apb_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  soc_bus_pkg::tgt_req_t  req_i,
  output soc_bus_pkg::tgt_rsp_t  rsp_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [`SOC_ADDR_W-1:0] paddr_o,
  output logic [`SOC_APB_W-1:0]  pwdata_o,
  input  logic [`SOC_APB_W-1:0]  prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e                 state_q;
  logic [`SOC_ADDR_W-1:0] paddr_q;
  logic [`SOC_APB_W-1:0]  pwdata_q;
  logic                   pwrite_q;
  logic [`SOC_APB_W-1:0]  prdata_q;
  logic                   pslverr_q;
  logic                   done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i.valid) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        default: begin
          // Slave may stretch access
          if (pready_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && req_i.valid) begin
      paddr_q  <= req_i.addr;
      pwdata_q <= req_i.wdata[`SOC_APB_W-1:0];
      pwrite_q <= req_i.we;
    end
    if ((state_q == ST_ACCESS) && pready_i) begin
      prdata_q  <= prdata_i;
      pslverr_q <= pslverr_i;
    end
  end

  assign psel_o    = (state_q != ST_IDLE);
  assign penable_o = (state_q == ST_ACCESS);
  assign pwrite_o  = pwrite_q;
  assign paddr_o   = paddr_q;
  assign pwdata_o  = pwdata_q;

  assign rsp_o.done  = done_q;
  assign rsp_o.rdata = {{(`SOC_DATA_W - `SOC_APB_W){1'b0}}, prdata_q};
  assign rsp_o.err   = pslverr_q;

  // Access must follow a setup cycle
  a_setup_before_access: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(penable_o) |-> (psel_o && $past(psel_o)))
    else $error("uart_apb_bridge: penable without setup phase");

endmodule

// File: soc_fabric_top.f
+incdir+include
rtl/soc_map_pkg.sv
rtl/soc_bus_pkg.sv
rtl/credit_req_queue.sv
rtl/addr_router.sv
rtl/l2_mem.sv
rtl/uart_apb_bridge.sv
rtl/ctrl_regs.sv
rtl/soc_fabric_top.sv
verif/tb_clk_gen.sv
verif/soc_fabric_tb.sv

// File: verif/soc_fabric_tb.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_fabric_tb;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int          Timeout  = 100;
  localparam logic [15:0] LfsrSeed = 16'd28183;

  logic                   clk;
  logic                   rst_i          = 1'b1;
  logic                   req_valid_i    = 1'b0;
  bus_req_t               req_i          = '0;
  logic                   credit_o;
  logic                   rsp_valid_o;
  bus_rsp_t               rsp_o;
  logic [`SOC_DATA_W-1:0] exit_o;
  logic [`SOC_DATA_W-1:0] hw_cnt_en_o;
  logic                   uart_psel_o;
  logic                   uart_penable_o;
  logic                   uart_pwrite_o;
  logic [`SOC_ADDR_W-1:0] uart_paddr_o;
  logic [`SOC_APB_W-1:0]  uart_pwdata_o;
  logic [`SOC_APB_W-1:0]  uart_prdata_i  = '0;
  logic                   uart_pready_i  = 1'b0;
  logic                   uart_pslverr_i = 1'b0;

  bus_rsp_t    rsp_fifo [$];
  int          credits_back = 0;
  int          reqs_sent    = 0;
  int          err_count    = 0;
  logic [15:0] test_lfsr    = LfsrSeed;
  logic [15:0] apb_lfsr     = LfsrSeed;

  // APB slave model state
  logic [`SOC_APB_W-1:0]  uart_regs [16];
  int                     wait_left;
  logic                   setup_seen;
  int                     apb_order_err;
  logic [`SOC_ADDR_W-1:0] apb_addr_seen;
  logic [`SOC_APB_W-1:0]  apb_wdata_seen;
  logic                   apb_write_seen;

  tb_clk_gen #(.PeriodNs(8)) i_clk_gen (.clk_o(clk));

  soc_fabric_top dut (
    .clk_i         (clk           ),
    .rst_i         (rst_i         ),
    .req_valid_i   (req_valid_i   ),
    .req_i         (req_i         ),
    .credit_o      (credit_o      ),
    .rsp_valid_o   (rsp_valid_o   ),
    .rsp_o         (rsp_o         ),
    .exit_o        (exit_o        ),
    .hw_cnt_en_o   (hw_cnt_en_o   ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] st, input int n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      st  = lfsr_next(st);
      val = {val[30:0], st[0]};
    end
  endtask

  function automatic logic [`SOC_APB_W-1:0] uart_fill(input int idx);
    return 32'h5A5A_0000 ^ (32'(idx) * 32'h0001_0203);
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string test, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected) begin
      err_count++;
      $display("ERR %s: expected %h, actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    abort_run();
  endtask

  //////////////////////////////
  // Host side
  //////////////////////////////
  always @(negedge clk) begin
    if (!rst_i) begin
      if (credit_o) begin
        credits_back++;
      end
      if (rsp_valid_o) begin
        rsp_fifo.push_back(rsp_o);
      end
    end
  end

  // Entered and left on a rising edge
  task automatic send_req(input bus_req_t r);
    int waited;
    waited = 0;
    while (`SOC_REQ_CREDITS + credits_back - reqs_sent == 0) begin
      @(posedge clk);
      waited++;
      if (waited > Timeout) begin
        report_timeout("a request credit");
      end
    end
    req_valid_i <= 1'b1;
    req_i       <= r;
    reqs_sent++;
    @(posedge clk);
  endtask

  task automatic recv_rsp(output bus_rsp_t r);
    int waited;
    waited = 0;
    while (rsp_fifo.size() == 0) begin
      @(posedge clk);
      waited++;
      if (waited > Timeout) begin
        report_timeout("a response");
      end
    end
    r = rsp_fifo.pop_front();
  endtask

  task automatic transact(input string test, input logic [`SOC_TAG_W-1:0] tag,
                          input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                          input logic [`SOC_DATA_W-1:0] wdata,
                          input logic [`SOC_STRB_W-1:0] strb, input logic exp_err,
                          input logic [`SOC_DATA_W-1:0] exp_rdata);
    bus_req_t q;
    bus_rsp_t r;
    q.tag   = tag;
    q.we    = we;
    q.addr  = addr;
    q.wdata = wdata;
    q.strb  = strb;
    send_req(q);
    req_valid_i <= 1'b0;
    recv_rsp(r);
    check_val($sformatf("%s tag", test), 64'(tag), 64'(r.tag));
    check_val($sformatf("%s err", test), 64'(exp_err), 64'(r.err));
    if (!we) begin
      check_val($sformatf("%s rdata", test), exp_rdata, r.rdata);
    end
  endtask

  //////////////////////////////
  // APB UART model
  //////////////////////////////
  always @(posedge clk) begin
    int unsigned dly;
    logic        finish_now;
    finish_now = 1'b0;
    if (rst_i) begin
      uart_pready_i  <= 1'b0;
      uart_pslverr_i <= 1'b0;
      uart_prdata_i  <= '0;
      setup_seen     <= 1'b0;
      wait_left      <= 0;
      apb_order_err  <= 0;
      for (int i = 0; i < 16; i++) begin
        uart_regs[i] <= uart_fill(i);
      end
    end else begin
      uart_pready_i <= 1'b0;
      if (uart_penable_o && !setup_seen) begin
        apb_order_err <= apb_order_err + 1;
      end
      if (uart_psel_o && !uart_penable_o) begin
        draw_bits(apb_lfsr, 2, dly);
        setup_seen     <= 1'b1;
        apb_addr_seen  <= uart_paddr_o;
        apb_wdata_seen <= uart_pwdata_o;
        apb_write_seen <= uart_pwrite_o;
        wait_left      <= int'(dly);
        finish_now     = (dly == 0);
      end else if (uart_psel_o && uart_penable_o) begin
        if (uart_pready_i) begin
          setup_seen <= 1'b0;
        end else if (wait_left <= 1) begin
          finish_now = 1'b1;
        end else begin
          wait_left <= wait_left - 1;
        end
      end
      if (finish_now) begin
        uart_pready_i <= 1'b1;
        if (uart_paddr_o[11:0] == 12'hFF0) begin
          uart_pslverr_i <= 1'b1;
          uart_prdata_i  <= '0;
        end else begin
          uart_pslverr_i <= 1'b0;
          uart_prdata_i  <= uart_regs[uart_paddr_o[5:2]];
          if (uart_pwrite_o) begin
            uart_regs[uart_paddr_o[5:2]] <= uart_pwdata_o;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic test_reset();
    @(negedge clk);
    check_val("reset rsp_valid_o", 64'd0, 64'(rsp_valid_o));
    check_val("reset credit_o", 64'd0, 64'(credit_o));
    check_val("reset uart_psel_o", 64'd0, 64'(uart_psel_o));
    check_val("reset uart_penable_o", 64'd0, 64'(uart_penable_o));
    check_val("reset exit_o", 64'd0, exit_o);
    check_val("reset hw_cnt_en_o", 64'd0, hw_cnt_en_o);
    @(posedge clk);
  endtask

  task automatic test_l2();
    logic [`SOC_ADDR_W-1:0] a;
    a = DRAM_BASE + 32'h40;
    transact("l2 full write", 4'd1, 1'b1, a, 64'h1122_3344_5566_7788, 8'hFF, 1'b0, '0);
    // Lanes 0, 1, 4 and 6 take the new bytes
    transact("l2 partial write", 4'd2, 1'b1, a, 64'hAABB_CCDD_EEFF_0011, 8'h53, 1'b0, '0);
    transact("l2 merged read", 4'd3, 1'b0, a, '0, 8'hFF, 1'b0, 64'h11BB_33DD_5566_0011);
  endtask

  task automatic test_ctrl();
    transact("ctrl exit write", 4'd4, 1'b1, CTRL_BASE + CTRL_EXIT_OFS, 64'h1, 8'hFF,
             1'b0, '0);
    check_val("ctrl exit_o", 64'h1, exit_o);
    transact("ctrl cnt_en write", 4'd5, 1'b1, CTRL_BASE + CTRL_CNT_EN_OFS, '1, 8'h0F,
             1'b0, '0);
    check_val("ctrl hw_cnt_en_o", 64'h0000_0000_FFFF_FFFF, hw_cnt_en_o);
    transact("ctrl exit read", 4'd6, 1'b0, CTRL_BASE + CTRL_EXIT_OFS, '0, 8'hFF,
             1'b0, 64'h1);
    transact("ctrl cnt_en read", 4'd7, 1'b0, CTRL_BASE + CTRL_CNT_EN_OFS, '0, 8'hFF,
             1'b0, 64'h0000_0000_FFFF_FFFF);
    transact("ctrl dram base read", 4'd8, 1'b0, CTRL_BASE + CTRL_DRAM_BASE_OFS, '0, 8'hFF,
             1'b0, 64'h0000_0000_8000_0000);
    transact("ctrl dram base write", 4'd9, 1'b1, CTRL_BASE + CTRL_DRAM_BASE_OFS,
             64'h1234, 8'hFF, 1'b1, '0);
    transact("ctrl unused read", 4'd10, 1'b0, CTRL_BASE + 32'h18, '0, 8'hFF, 1'b1, '0);
  endtask

  task automatic test_uart();
    transact("uart write", 4'd11, 1'b1, UART_BASE + 32'h24, 64'h0000_0000_CAFE_F00D,
             8'hFF, 1'b0, '0);
    check_val("uart paddr", 64'h24, 64'(apb_addr_seen));
    check_val("uart pwdata", 64'hCAFE_F00D, 64'(apb_wdata_seen));
    check_val("uart pwrite", 64'h1, 64'(apb_write_seen));
    check_val("uart psel before penable", 64'd0, 64'(apb_order_err));
    transact("uart read back", 4'd12, 1'b0, UART_BASE + 32'h24, '0, 8'hFF, 1'b0,
             64'h0000_0000_CAFE_F00D);
    transact("uart fill read", 4'd13, 1'b0, UART_BASE + 32'h08, '0, 8'hFF, 1'b0,
             64'(uart_fill(2)));
    transact("uart slave error", 4'd14, 1'b0, UART_BASE + 32'hFF0, '0, 8'hFF, 1'b1, '0);
  endtask

  task automatic test_order();
    bus_req_t               q;
    bus_rsp_t               r;
    logic [`SOC_DATA_W-1:0] exp_data [4];
    logic                   exp_err [4];
    logic [`SOC_TAG_W-1:0]  exp_tag [4];
    int unsigned            pick;
    int                     base_credits;
    transact("unmapped read", 4'd15, 1'b0, 32'h1000_0000, '0, 8'hFF, 1'b1, '0);
    base_credits = credits_back;
    for (int i = 0; i < 4; i++) begin
      draw_bits(test_lfsr, 2, pick);
      q           = '0;
      q.tag       = 4'(i + 1);
      q.strb      = 8'hFF;
      exp_tag[i]  = q.tag;
      exp_err[i]  = 1'b0;
      case (pick)
        0: begin
          q.addr      = DRAM_BASE + 32'h40;
          exp_data[i] = 64'h11BB_33DD_5566_0011;
        end
        1: begin
          q.addr      = UART_BASE + 32'h24;
          exp_data[i] = 64'h0000_0000_CAFE_F00D;
        end
        2: begin
          q.addr      = CTRL_BASE + CTRL_CNT_EN_OFS;
          exp_data[i] = 64'h0000_0000_FFFF_FFFF;
        end
        default: begin
          q.addr      = 32'h0000_1000;
          exp_data[i] = '0;
          exp_err[i]  = 1'b1;
        end
      endcase
      send_req(q);
    end
    req_valid_i <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      recv_rsp(r);
      check_val($sformatf("order tag %0d", i), 64'(exp_tag[i]), 64'(r.tag));
      check_val($sformatf("order err %0d", i), 64'(exp_err[i]), 64'(r.err));
      check_val($sformatf("order rdata %0d", i), exp_data[i], r.rdata);
    end
    check_val("order credits", 64'd4, 64'(credits_back - base_credits));
  endtask

  initial begin
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    test_reset();
    test_l2();
    test_ctrl();
    test_uart();
    test_order();
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PeriodNs = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule
